// File: flist.f
src/dps_pkg.sv
src/dps_cmd_if.sv
src/reset_lock_ctrl.sv
src/phase_step_map.sv
src/phaser.sv
src/clock_sense.sv
src/clock_ctrl.sv
sim/tb_clock_ctrl.sv

// File: Makefile
# Verilator build and run for the clock control block

VERILATOR  ?= verilator
TOP        := tb_clock_ctrl
FLIST      := flist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
FAIL_MSG   := Done: errors found
PASS_MSG   := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended early"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_clock_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_ctrl;

  import dps_pkg::*;

  localparam int NUM_ROWS   = 10;
  localparam int WAIT_LIMIT = 200;   // Cycles for a state change
  localparam int MOVE_LIMIT = 8000;  // Cycles for a full move
  localparam logic [NUM_SENSE-1:0] SENSE_TOGGLE = 7'b1010101;  // Running clocks
  localparam logic [NUM_SENSE-1:0] SENSE_HELD   = 7'b0100010;  // Stuck levels

  logic                     clock;
  logic                     rst_n;
  logic                     lock_main;
  logic                     global_reset_en;
  logic [NUM_DPS-1:0]       dps_fire;
  logic [NUM_DPS-1:0]       dps_reset;
  logic [NUM_DPS-1:0]       dps_lock;
  logic [NUM_DPS-1:0]       psdone;
  vme_phase_t [NUM_DPS-1:0] dps_phase;
  logic [NUM_SENSE-1:0]     clock_sense_in;
  logic                     global_reset;
  logic                     clock_lock_lost_err;
  logic [NUM_DPS-1:0]       dps_busy;
  logic [NUM_DPS-1:0]       psen;
  logic [NUM_DPS-1:0]       psincdec;
  dps_state_t [NUM_DPS-1:0] dps_sm_vec;
  logic [NUM_SENSE-1:0]     clock_sense_ok;

  int up_cnt    [NUM_DPS];  // psen pulses with psincdec high
  int dn_cnt    [NUM_DPS];  // psen pulses with psincdec low
  int model_pos [NUM_DPS];  // Expected fine step position

  //----------------------------------------------------------------------
  // Stimulus table, one move per row
  //----------------------------------------------------------------------
  int row_ch    [NUM_ROWS] = '{0, 1, 0, 2, 1, 3, 1, 0, 2, 3};
  int row_phase [NUM_ROWS] = '{10, 64, 3, 20, 128, 1, 64, 3, 10, 0};
  int row_clear [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 1, 0, 1, 0};      // Clear before fire
  int row_count [NUM_ROWS] = '{55, 350, 39, 109, 350, 5, 350, 0, 55, 5};
  int row_up    [NUM_ROWS] = '{1, 1, 0, 1, 1, 1, 1, 0, 1, 0};      // 1 for increment

  clock_ctrl u_dut (
    .clock               (clock),
    .rst_n               (rst_n),
    .lock_main           (lock_main),
    .global_reset_en     (global_reset_en),
    .dps_fire            (dps_fire),
    .dps_reset           (dps_reset),
    .dps_lock            (dps_lock),
    .psdone              (psdone),
    .dps_phase           (dps_phase),
    .clock_sense_in      (clock_sense_in),
    .global_reset        (global_reset),
    .clock_lock_lost_err (clock_lock_lost_err),
    .dps_busy            (dps_busy),
    .psen                (psen),
    .psincdec            (psincdec),
    .dps_sm_vec          (dps_sm_vec),
    .clock_sense_ok      (clock_sense_ok)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;  // 8 ns period
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Nearest fine step, 1400/256 reduced to 175/32
  function automatic int nearest_step(input int phase);
    int whole;
    int rem;
    whole = (phase * 175) / 32;
    rem   = (phase * 175) % 32;
    if (rem >= 16) begin
      whole = whole + 1;  // Half rounds up
    end
    return whole;
  endfunction

  //----------------------------------------------------------------------
  // MMCM model and pulse counters
  //----------------------------------------------------------------------
  initial begin : done_model
    logic [31:0]        rng;
    logic [NUM_DPS-1:0] hit;
    int                 delay;
    rng = 32'h2206;
    psdone <= '0;
    forever begin
      @(negedge clock);
      hit = psen;
      if (hit != '0) begin
        rng   = xorshift(rng);
        delay = 1 + int'(rng % 5);  // 1 to 5 cycles
        repeat (delay) @(posedge clock);
        psdone <= hit;
        @(posedge clock);
        psdone <= '0;  // One cycle pulse
      end
    end
  end

  always @(negedge clock) begin
    for (int i = 0; i < NUM_DPS; i++) begin
      if (psen[i] && psincdec[i]) up_cnt[i] <= up_cnt[i] + 1;
      if (psen[i] && !psincdec[i]) dn_cnt[i] <= dn_cnt[i] + 1;
    end
  end

  //----------------------------------------------------------------------
  // Compare and wait tasks
  //----------------------------------------------------------------------
  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_step(input string name, input fine_step_t got, input fine_step_t exp);
    if (got !== exp) fail_now($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_state(input string name, input dps_state_t got, input dps_state_t exp);
    if (got !== exp) fail_now($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_sense(input string name, input logic [NUM_SENSE-1:0] got,
                             input logic [NUM_SENSE-1:0] exp);
    if (got !== exp) fail_now($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic wait_reset_level(input logic level);
    int n;
    n = 0;
    while (global_reset !== level && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (global_reset !== level) fail_now("timeout waiting for global_reset to change");
  endtask

  task automatic wait_state(input int ch, input dps_state_t st, input int limit);
    int n;
    n = 0;
    while (dps_sm_vec[ch] !== st && n < limit) begin
      @(negedge clock);
      n++;
    end
    if (dps_sm_vec[ch] !== st) fail_now($sformatf("timeout waiting for state %s on channel %0d",
                                                  st.name(), ch));
  endtask

  task automatic wait_busy_low(input int ch);
    int n;
    n = 0;
    while (dps_busy[ch] !== 1'b0 && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (dps_busy[ch] !== 1'b0) fail_now($sformatf("busy stuck high on channel %0d", ch));
  endtask

  task automatic wait_all_idle();
    for (int ch = 0; ch < NUM_DPS; ch++) wait_state(ch, ST_IDLE, WAIT_LIMIT);
  endtask

  task automatic run_row(input int r);
    int ch;
    int exp_pos;
    int delta;
    int up0 [NUM_DPS];
    int dn0 [NUM_DPS];
    ch = row_ch[r];
    if (row_clear[r] != 0) begin
      @(posedge clock);
      dps_reset[ch] <= 1'b1;
      @(posedge clock);
      dps_reset[ch] <= 1'b0;
      @(negedge clock);
      check_state("dps_sm_vec after clear", dps_sm_vec[ch], ST_WAIT_DPS);
      wait_state(ch, ST_IDLE, WAIT_LIMIT);
      model_pos[ch] = 0;  // Clear homes the phase
    end
    @(posedge clock);
    dps_phase[ch] <= vme_phase_t'(row_phase[r]);
    repeat (2) @(posedge clock);  // Target loads one cycle later
    up0 = up_cnt;
    dn0 = dn_cnt;
    dps_fire[ch] <= 1'b1;
    wait_state(ch, ST_UNFIRE, MOVE_LIMIT);
    check_flag("dps_busy during fire", dps_busy[ch], 1'b1);
    @(posedge clock);
    dps_fire[ch] <= 1'b0;
    wait_busy_low(ch);
    check_state("dps_sm_vec after move", dps_sm_vec[ch], ST_IDLE);
    exp_pos = nearest_step(row_phase[r]);
    delta   = exp_pos - model_pos[ch];
    check_step("table count", fine_step_t'(delta < 0 ? -delta : delta),
               fine_step_t'(row_count[r]));
    if (row_count[r] != 0) check_flag("table direction", logic'(delta > 0), logic'(row_up[r] != 0));
    for (int i = 0; i < NUM_DPS; i++) begin
      if (i == ch) begin
        check_step("psen up count", fine_step_t'(up_cnt[i] - up0[i]),
                   fine_step_t'(row_up[r] != 0 ? row_count[r] : 0));
        check_step("psen down count", fine_step_t'(dn_cnt[i] - dn0[i]),
                   fine_step_t'(row_up[r] != 0 ? 0 : row_count[r]));
      end else begin
        check_step("psen idle channel", fine_step_t'(up_cnt[i] + dn_cnt[i] - up0[i] - dn0[i]),
                   fine_step_t'(0));
      end
    end
    model_pos[ch] = exp_pos;
  endtask

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------
  initial begin : stimulus
    rst_n           <= 1'b0;
    lock_main       <= 1'b0;
    global_reset_en <= 1'b0;
    dps_fire        <= '0;
    dps_reset       <= '0;
    dps_lock        <= '0;
    dps_phase       <= '0;
    clock_sense_in  <= SENSE_HELD;
    repeat (10) @(posedge clock);
    rst_n <= 1'b1;

    for (int n = 0; n < 6; n++) begin  // No lock yet, everything parked
      @(negedge clock);
      check_flag("global_reset", global_reset, 1'b1);
      check_flag("psen any", |psen, 1'b0);
      check_flag("dps_busy any", |dps_busy, 1'b0);
      for (int ch = 0; ch < NUM_DPS; ch++) check_state("dps_sm_vec", dps_sm_vec[ch], ST_WAIT_MAIN);
    end
    @(posedge clock);
    lock_main <= 1'b1;
    dps_lock  <= '1;
    wait_reset_level(1'b0);
    check_flag("clock_lock_lost_err", clock_lock_lost_err, 1'b0);
    wait_all_idle();

    @(posedge clock);
    lock_main <= 1'b0;  // Loss with re-fire off
    repeat (3) begin
      @(negedge clock);
      check_flag("clock_lock_lost_err", clock_lock_lost_err, 1'b1);
      check_flag("global_reset", global_reset, 1'b0);
    end
    @(posedge clock);
    lock_main <= 1'b1;
    @(negedge clock);
    check_flag("clock_lock_lost_err", clock_lock_lost_err, 1'b0);
    wait_all_idle();

    @(posedge clock);
    global_reset_en <= 1'b1;  // Loss with re-fire on
    lock_main       <= 1'b0;
    wait_reset_level(1'b1);
    check_flag("clock_lock_lost_err", clock_lock_lost_err, 1'b0);
    for (int ch = 0; ch < NUM_DPS; ch++) check_state("dps_sm_vec", dps_sm_vec[ch], ST_WAIT_MAIN);
    @(posedge clock);
    lock_main <= 1'b1;
    wait_reset_level(1'b0);
    @(posedge clock);
    global_reset_en <= 1'b0;
    wait_all_idle();

    for (int r = 0; r < NUM_ROWS; r++) run_row(r);

    @(posedge clock);
    #2;
    check_sense("clock_sense_ok held", clock_sense_ok, '0);
    for (int n = 0; n < 8; n++) begin  // Toggle on both edges
      @(posedge clock);
      clock_sense_in <= clock_sense_in ^ SENSE_TOGGLE;
      #2;
      if (n >= 1) check_sense("clock_sense_ok", clock_sense_ok, SENSE_TOGGLE);
      @(negedge clock);
      clock_sense_in <= clock_sense_in ^ SENSE_TOGGLE;
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/clock_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl (
  input  logic                                       clock,
  input  logic                                       rst_n,
  input  logic                                       lock_main,        // Main PLL lock
  input  logic                                       global_reset_en,  // Re-fire on lock loss
  input  logic [dps_pkg::NUM_DPS-1:0]                dps_fire,         // VME set new phase
  input  logic [dps_pkg::NUM_DPS-1:0]                dps_reset,        // VME reset phase
  input  logic [dps_pkg::NUM_DPS-1:0]                dps_lock,         // Shifter MMCM locks
  input  logic [dps_pkg::NUM_DPS-1:0]                psdone,           // Shifter MMCM done
  input  dps_pkg::vme_phase_t [dps_pkg::NUM_DPS-1:0] dps_phase,        // VME phase 0-255
  input  logic [dps_pkg::NUM_SENSE-1:0]              clock_sense_in,   // Sensed clocks
  output logic                                       global_reset,
  output logic                                       clock_lock_lost_err,
  output logic [dps_pkg::NUM_DPS-1:0]                dps_busy,         // Move in progress
  output logic [dps_pkg::NUM_DPS-1:0]                psen,             // Step enable
  output logic [dps_pkg::NUM_DPS-1:0]                psincdec,         // Step direction
  output dps_pkg::dps_state_t [dps_pkg::NUM_DPS-1:0] dps_sm_vec,       // Phaser states
  output logic [dps_pkg::NUM_SENSE-1:0]              clock_sense_ok    // Clock running
);

  import dps_pkg::*;

  logic run_en;  // Phaser gate from lock control

  dps_cmd_if cmd [NUM_DPS] ();  // One request channel per shifter

  //--------------------------------------------------------------------
  // Reset and lock
  //--------------------------------------------------------------------
  reset_lock_ctrl u_reset_lock_ctrl (
    .clock               (clock),
    .rst_n               (rst_n),
    .lock_main           (lock_main),
    .global_reset_en     (global_reset_en),
    .global_reset        (global_reset),
    .clock_lock_lost_err (clock_lock_lost_err),
    .run_en              (run_en)
  );

  //--------------------------------------------------------------------
  // Phase table and shifters
  //--------------------------------------------------------------------
  phase_step_map u_phase_step_map (
    .clock     (clock),
    .rst_n     (rst_n),
    .dps_fire  (dps_fire),
    .dps_reset (dps_reset),
    .dps_phase (dps_phase),
    .cmd       (cmd)
  );

  genvar i;

  generate
    for (i = 0; i < NUM_DPS; i++) begin : g_dps
      phaser u_phaser (
        .clock    (clock),
        .rst_n    (rst_n),
        .run_en   (run_en),
        .dps_lock (dps_lock[i]),
        .psdone   (psdone[i]),
        .cmd      (cmd[i]),
        .psen     (psen[i]),
        .psincdec (psincdec[i]),
        .sm_vec   (dps_sm_vec[i])
      );

      assign dps_busy[i] = cmd[i].busy;  // Status back to VME
    end
  endgenerate

  //--------------------------------------------------------------------
  // Clock presence
  //--------------------------------------------------------------------
  clock_sense u_clock_sense (
    .clock    (clock),
    .rst_n    (rst_n),
    .sense_in (clock_sense_in),
    .sense_ok (clock_sense_ok)
  );

endmodule

`default_nettype wire

// File: src/clock_sense.sv
`timescale 1ns/1ps
`default_nettype none

module clock_sense (
  input  logic                          clock,
  input  logic                          rst_n,
  input  logic [dps_pkg::NUM_SENSE-1:0] sense_in,  // Clock inputs to watch
  output logic [dps_pkg::NUM_SENSE-1:0] sense_ok   // Input seen toggling
);

  import dps_pkg::*;

  //--------------------------------------------------------------------
  // Dual edge samples
  //--------------------------------------------------------------------
  logic [NUM_SENSE-1:0] rise_q;  // Taken on rising edge
  logic [NUM_SENSE-1:0] fall_q;  // Taken on falling edge

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rise_q <= '0;
    end else begin
      rise_q <= sense_in;
    end
  end

  always_ff @(negedge clock or negedge rst_n) begin
    if (!rst_n) begin
      fall_q <= '0;
    end else begin
      fall_q <= sense_in;
    end
  end

  //--------------------------------------------------------------------
  // Presence
  //--------------------------------------------------------------------
  // A running copy of the main clock flips between the two half
  // periods, a stuck input gives equal samples
  assign sense_ok = rise_q ^ fall_q;

endmodule

`default_nettype wire

// File: src/phaser.sv
`timescale 1ns/1ps
`default_nettype none

module phaser (
  input  logic                clock,
  input  logic                rst_n,
  input  logic                run_en,    // Main lock up, global reset off
  input  logic                dps_lock,  // This MMCM locked
  input  logic                psdone,    // MMCM step finished, one cycle
  dps_cmd_if.phaser_side      cmd,       // Fire, clear, target, busy
  output logic                psen,      // MMCM step enable, one cycle
  output logic                psincdec,  // 1 increments phase
  output dps_pkg::dps_state_t sm_vec     // FSM state to VME
);

  import dps_pkg::*;

  //--------------------------------------------------------------------
  // Sequencer state
  //--------------------------------------------------------------------
  dps_state_t state;     // Current FSM state
  fine_step_t position;  // Fine steps applied since last clear
  logic       busy;      // Move in progress
  logic       go_up;     // Target lies above position

  assign go_up = cmd.target > position;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_WAIT_MAIN;
      position <= '0;
      busy     <= 1'b0;
      psen     <= 1'b0;
      psincdec <= 1'b0;
    end else begin
      psen <= 1'b0;  // Single cycle pulse by default

      if (!run_en) begin
        state <= ST_WAIT_MAIN;  // Main clock gone or reset
        busy  <= 1'b0;
      end else if (cmd.clear) begin
        state    <= ST_WAIT_DPS;  // MMCM is reset, relock first
        position <= '0;           // Phase back to zero
        busy     <= 1'b0;
      end else begin
        case (state)
          ST_WAIT_MAIN: begin
            state <= ST_WAIT_DPS;  // run_en is high here
          end

          ST_WAIT_DPS: begin
            if (dps_lock) begin
              state <= ST_IDLE;
            end
          end

          ST_IDLE: begin
            if (cmd.fire) begin
              state <= ST_STEP;
              busy  <= 1'b1;  // Freezes target in the map
            end
          end

          ST_STEP: begin
            if (position == cmd.target) begin
              state <= ST_UNFIRE;  // Arrived
            end else begin
              psen     <= 1'b1;
              psincdec <= go_up;
              state    <= ST_WAIT_DONE;
              if (go_up) begin
                position <= position + fine_step_t'(1);
              end else begin
                position <= position - fine_step_t'(1);
              end
            end
          end

          ST_WAIT_DONE: begin
            if (psdone) begin
              state <= ST_STEP;  // Next step or finish
            end
          end

          ST_UNFIRE: begin
            if (!cmd.fire) begin
              state <= ST_IDLE;
              busy  <= 1'b0;  // End of move
            end
          end

          default: begin
            state <= ST_WAIT_MAIN;  // Unused codes recover
          end
        endcase
      end
    end
  end

  assign cmd.busy = busy;
  assign sm_vec   = state;

  //--------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------
  a_psen_pulse : assert property (
    @(posedge clock) disable iff (!rst_n)
    psen |=> !psen
  ) else $error("psen high on consecutive cycles");

  a_position_range : assert property (
    @(posedge clock) disable iff (!rst_n)
    position <= fine_step_t'(STEPS_PER_CYCLE - 1)
  ) else $error("position beyond one cycle");

endmodule

`default_nettype wire

// File: src/phase_step_map.sv
`timescale 1ns/1ps
`default_nettype none

module phase_step_map (
  input  logic                                       clock,
  input  logic                                       rst_n,
  input  logic [dps_pkg::NUM_DPS-1:0]                dps_fire,   // VME fire per channel
  input  logic [dps_pkg::NUM_DPS-1:0]                dps_reset,  // VME clear per channel
  input  dps_pkg::vme_phase_t [dps_pkg::NUM_DPS-1:0] dps_phase,  // VME phase per channel
  dps_cmd_if.map_side                                cmd [dps_pkg::NUM_DPS]
);

  import dps_pkg::*;

  genvar ch;

  //--------------------------------------------------------------------
  // Per channel target hold and request routing
  //--------------------------------------------------------------------
  generate
    for (ch = 0; ch < NUM_DPS; ch++) begin : g_chan

      fine_step_t step_lut;  // Table value for current VME phase

      assign step_lut = phase_to_step(dps_phase[ch]);

      // Track the VME phase while idle and freeze during a move
      always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
          cmd[ch].target <= '0;  // Matches phaser home position
        end else if (!cmd[ch].busy) begin
          cmd[ch].target <= step_lut;
        end
      end

      assign cmd[ch].fire  = dps_fire[ch];   // Straight through
      assign cmd[ch].clear = dps_reset[ch];  // Straight through

      // Goal must not move under a running phaser
      a_target_hold : assert property (
        @(posedge clock) disable iff (!rst_n)
        cmd[ch].busy |=> $stable(cmd[ch].target)
      ) else $error("target changed during move on channel %0d", ch);

    end
  endgenerate

endmodule

`default_nettype wire

// File: src/reset_lock_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module reset_lock_ctrl (
  input  logic clock,
  input  logic rst_n,
  input  logic lock_main,            // Main PLL lock
  input  logic global_reset_en,      // Re-fire reset when lock drops
  output logic global_reset,         // FPGA-wide reset held high until first lock
  output logic clock_lock_lost_err,  // Main lock lost without reset
  output logic run_en                // Gates all phasers
);

  //--------------------------------------------------------------------
  // First-lock latch and global reset
  //--------------------------------------------------------------------
  logic startup_done;  // Sticky once the main PLL has locked
  logic first_lock;    // Lock now or at any time before

  assign first_lock = lock_main | startup_done;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      startup_done <= 1'b0;  // No lock seen yet
      global_reset <= 1'b1;  // Held until first lock
    end else begin
      startup_done <= first_lock;                                     // Latches on first lock
      global_reset <= !first_lock || (!lock_main && global_reset_en);  // Re-fire on loss
    end
  end

  //--------------------------------------------------------------------
  // Status and run enable
  //--------------------------------------------------------------------
  // Lock dropped while reset stays off because re-fire is disabled
  // or the reset register has not caught up yet
  assign clock_lock_lost_err = !global_reset && !lock_main;

  assign run_en = lock_main && !global_reset;  // Phasers may leave WAIT_MAIN

  //--------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------
  // Error only has meaning once the clock has locked at least once
  a_no_err_before_lock : assert property (
    @(posedge clock) disable iff (!rst_n)
    !startup_done |-> !clock_lock_lost_err
  ) else $error("lock lost error before first lock");

endmodule

`default_nettype wire

// File: src/dps_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dps_cmd_if;

  import dps_pkg::*;

  logic       fire;    // VME set new phase, level
  logic       clear;   // VME reset of current phase, level
  fine_step_t target;  // Fine step goal for the move
  logic       busy;    // Move in progress, level

  // Phase table side, owns the request
  modport map_side (
    output fire,
    output clear,
    output target,
    input  busy
  );

  // Sequencer side, owns the status
  modport phaser_side (
    input  fire,
    input  clear,
    input  target,
    output busy
  );

  // target only reloads while busy is low
  // so a move always sees one fixed goal

endinterface

`default_nettype wire

// File: src/dps_pkg.sv
`default_nettype none

package dps_pkg;

  //--------------------------------------------------------------------
  // Channel counts
  //--------------------------------------------------------------------
  localparam int NUM_DPS   = 4;  // 2 ALCT + 2 DCFEB groups
  localparam int NUM_SENSE = 7;  // Clock inputs watched for activity

  //--------------------------------------------------------------------
  // Phase scales
  //--------------------------------------------------------------------
  localparam int PHASE_W         = 8;     // VME phase width
  localparam int STEP_W          = 11;    // MMCM fine step width
  localparam int STEPS_PER_CYCLE = 1400;  // Fine steps across one 25 ns cycle
  localparam int PHASE_PER_CYCLE = 256;   // VME steps across one cycle

  typedef logic [PHASE_W-1:0] vme_phase_t;  // 0 to 255
  typedef logic [STEP_W-1:0]  fine_step_t;  // 0 to 1399

  // Phaser FSM codes, also reported to VME as sm_vec
  typedef enum logic [2:0] {
    ST_WAIT_MAIN = 3'd0,  // Main PLL not locked
    ST_WAIT_DPS  = 3'd1,  // Phase shift MMCM not locked
    ST_IDLE      = 3'd2,  // Ready for fire
    ST_STEP      = 3'd3,  // Compare position to target
    ST_WAIT_DONE = 3'd4,  // Step issued, waiting on psdone
    ST_UNFIRE    = 3'd5   // At target, waiting on fire release
  } dps_state_t;

  //--------------------------------------------------------------------
  // Phase table, VME phase to nearest fine step
  //--------------------------------------------------------------------
  function automatic fine_step_t phase_to_step(input vme_phase_t phase);
    int scaled;
    scaled = int'(phase) * STEPS_PER_CYCLE + PHASE_PER_CYCLE / 2;  // Round half up
    return fine_step_t'(scaled / PHASE_PER_CYCLE);                 // Max 1395, fits
  endfunction

endpackage

`default_nettype wire
